// File: design/fmau_defines.svh
/* Field widths and biases shared by the FMA issue datapath
   The function-word views assume format bits at 17:16 and arithmetic flags at 2:0 */

`ifndef FMAU_DEFINES_SVH
`define FMAU_DEFINES_SVH

// ====================
// Datapath widths
// ====================

// One vector element lane, also the container of a NaN-boxed single
`define FMAU_DATA_W 64

// Function word coming from the issue queue
`define FMAU_FUNC_W 20

// Rounding mode and forwarding id
`define FMAU_RM_W 3
`define FMAU_ID_W 2

// ====================
// IEEE 754 fields
// ====================

// Double precision
`define FMAU_DBL_EXP_W  11
`define FMAU_DBL_FRAC_W 52
`define FMAU_DBL_BIAS   1023

// Single precision
`define FMAU_SGL_EXP_W  8
`define FMAU_SGL_FRAC_W 23
`define FMAU_SGL_BIAS   127

`endif

// File: design/fmau_fmt_pkg.sv
/* Floating-point field layouts and the two views of the function word
   Only double and single formats are described, the box of a single is 32 bits */

`include "fmau_defines.svh"

package fmau_fmt_pkg;

  // ====================
  // Operand formats
  // ====================

  // Double as it sits in a 64-bit lane
  typedef struct packed {
    logic                         sign;
    logic [`FMAU_DBL_EXP_W-1:0]   exp;
    logic [`FMAU_DBL_FRAC_W-1:0]  frac;
  } fmau_dbl_t;

  // Single held in the low half, upper half all ones when valid
  typedef struct packed {
    logic [`FMAU_DATA_W-`FMAU_SGL_EXP_W-`FMAU_SGL_FRAC_W-2:0] box;
    logic                                                     sign;
    logic [`FMAU_SGL_EXP_W-1:0]                               exp;
    logic [`FMAU_SGL_FRAC_W-1:0]                              frac;
  } fmau_sgl_boxed_t;

  // ====================
  // Function word
  // ====================

  // Arithmetic view
  typedef struct packed {
    logic [`FMAU_FUNC_W-19:0] rsvd_hi;
    logic                     sgl;
    logic                     dbl;
    logic [12:0]              rsvd_mid;
    logic                     neg;
    logic                     sub;
    logic                     acc;
  } fmau_func_arith_t;

  // Scaleb view, bit 5 selects the power-of-two second source
  typedef struct packed {
    logic [`FMAU_FUNC_W-19:0] rsvd_hi;
    logic                     sgl;
    logic                     dbl;
    logic [9:0]               rsvd_mid;
    logic                     scaleb;
    logic [4:0]               rsvd_lo;
  } fmau_func_scaleb_t;

  // Same 20 bits, read either way
  typedef union packed {
    fmau_func_arith_t  arith;
    fmau_func_scaleb_t scl;
  } fmau_func_u;

endpackage

// File: design/fmau_pipe_pkg.sv
/* Decoded operation, operand set and per-stage control word
   Control words carry no payload, results stay outside this datapath */

`include "fmau_defines.svh"

package fmau_pipe_pkg;

  // ====================
  // EX1 decode result
  // ====================

  // Consumed by operand preparation
  typedef struct packed {
    logic dbl;
    logic sgl;
    logic neg;
    logic sub;
    logic acc;
    logic scaleb;
  } fmau_op_t;

  // ====================
  // Staged control
  // ====================

  // Travels EX1 through EX4
  typedef struct packed {
    logic                  dbl;
    logic                  sgl;
    logic                  neg;
    logic                  sub;
    logic [`FMAU_RM_W-1:0] rm;
    logic                  acc_upd;
  } fmau_ctrl_t;

  // ====================
  // Operands
  // ====================

  // srcv0 * srcv1 +/- srcv2
  typedef struct packed {
    logic [`FMAU_DATA_W-1:0] srcv0;
    logic [`FMAU_DATA_W-1:0] srcv1;
    logic [`FMAU_DATA_W-1:0] srcv2;
  } fmau_opnd_t;

endpackage

// File: design/fmau_inst_decode.sv
/* Combinational EX1 decode of function word, rounding mode and forwarding id
   Function bits outside the two views are ignored */

`include "fmau_defines.svh"

module fmau_inst_decode (
  input  fmau_fmt_pkg::fmau_func_u  func,
  input  logic [`FMAU_RM_W-1:0]     rm,
  input  logic [`FMAU_ID_W-1:0]     id_reg,
  output fmau_pipe_pkg::fmau_op_t   op,
  output fmau_pipe_pkg::fmau_ctrl_t ctrl_ex1
);

  logic                  scaleb;
  logic [`FMAU_ID_W-1:0] id_masked;

  // ====================
  // Function word
  // ====================

  // Scaleb has its own view of the word
  assign scaleb = func.scl.scaleb;

  always_comb
  begin
    op.dbl    = func.arith.dbl;
    op.sgl    = func.arith.sgl;
    op.neg    = func.arith.neg;
    op.sub    = func.arith.sub;
    op.acc    = func.arith.acc;
    op.scaleb = scaleb;
  end

  // ====================
  // Forwarding id
  // ====================

  // Upper id bit means nothing for scaleb
  assign id_masked = id_reg & {~scaleb, {(`FMAU_ID_W-1){1'b1}}};

  // ====================
  // Control word
  // ====================

  always_comb
  begin
    ctrl_ex1.dbl     = op.dbl;
    ctrl_ex1.sgl     = op.sgl;
    ctrl_ex1.neg     = op.neg;
    ctrl_ex1.sub     = op.sub;
    ctrl_ex1.rm      = rm;
    // Accumulator must be refreshed for mac or a forwarded addend
    ctrl_ex1.acc_upd = op.acc || (|id_masked);
  end

endmodule

// File: design/fmau_operand_prep.sv
/* Builds the three EX1 operands from the raw sources
   Scaleb exponents wrap modulo the field width, no saturation is applied */

`include "fmau_defines.svh"

module fmau_operand_prep (
  input  fmau_pipe_pkg::fmau_op_t   op,
  input  logic [`FMAU_DATA_W-1:0]   srcv0,
  input  logic [`FMAU_DATA_W-1:0]   srcv1,
  input  logic [`FMAU_DATA_W-1:0]   srcv2,
  output fmau_pipe_pkg::fmau_opnd_t opnd_ex1
);

  import fmau_fmt_pkg::*;

  localparam logic [`FMAU_DBL_EXP_W-1:0] DBL_BIAS = `FMAU_DBL_BIAS;
  localparam logic [`FMAU_SGL_EXP_W-1:0] SGL_BIAS = `FMAU_SGL_BIAS;

  logic [`FMAU_DBL_EXP_W-1:0] dbl_exp;
  logic [`FMAU_SGL_EXP_W-1:0] sgl_exp;
  fmau_dbl_t                  scaleb_dbl;
  fmau_sgl_boxed_t            scaleb_sgl;
  logic [`FMAU_DATA_W-1:0]    scaleb_srcv1;

  // ====================
  // Scaleb power of two
  // ====================

  // Integer operand becomes the biased exponent, overflow wraps
  assign dbl_exp = srcv1[`FMAU_DBL_EXP_W-1:0] + DBL_BIAS;
  assign sgl_exp = srcv1[`FMAU_SGL_EXP_W-1:0] + SGL_BIAS;

  always_comb
  begin
    scaleb_dbl      = '0;
    scaleb_dbl.exp  = dbl_exp;
    scaleb_sgl      = '0;
    scaleb_sgl.box  = '1;
    scaleb_sgl.exp  = sgl_exp;
  end

  // Anything not marked double gets the boxed single
  always_comb
  begin
    if (op.dbl)
    begin
      scaleb_srcv1 = scaleb_dbl;
    end
    else
    begin
      scaleb_srcv1 = scaleb_sgl;
    end
  end

  // ====================
  // Operand set
  // ====================

  always_comb
  begin
    opnd_ex1.srcv0 = srcv0;

    if (op.scaleb)
    begin
      opnd_ex1.srcv1 = scaleb_srcv1;
    end
    else
    begin
      opnd_ex1.srcv1 = srcv1;
    end

    // Addend only exists for accumulating ops
    if (op.acc)
    begin
      opnd_ex1.srcv2 = srcv2;
    end
    else
    begin
      opnd_ex1.srcv2 = '0;
    end
  end

endmodule

// File: design/fmau_stage_regs.sv
/* EX2 to EX4 stage registers, each stage advances on its own pipe-down strobe
   Warm-up forces every stage to load, operands also need a valid EX1 instruction */

module fmau_stage_regs (
  input  logic                      fmau_ex2_data_clk,
  input  logic                      rst,
  input  logic                      inst_vld_ex1,
  input  logic                      pipe_down_ex1,
  input  logic                      pipe_down_ex2,
  input  logic                      pipe_down_ex3,
  input  logic                      warm_up,
  input  fmau_pipe_pkg::fmau_ctrl_t ctrl_ex1,
  input  fmau_pipe_pkg::fmau_opnd_t opnd_ex1,
  output fmau_pipe_pkg::fmau_opnd_t opnd_ex2,
  output fmau_pipe_pkg::fmau_ctrl_t ctrl_ex2,
  output fmau_pipe_pkg::fmau_ctrl_t ctrl_ex3,
  output fmau_pipe_pkg::fmau_ctrl_t ctrl_ex4
);

  logic ld_ex2;
  logic ld_ex3;
  logic ld_ex4;
  logic ld_opnd_ex2;

  // ====================
  // Load enables
  // ====================

  assign ld_ex2 = pipe_down_ex1 || warm_up;
  assign ld_ex3 = pipe_down_ex2 || warm_up;
  assign ld_ex4 = pipe_down_ex3 || warm_up;

  // Operand register only moves for a real instruction
  assign ld_opnd_ex2 = ld_ex2 && (inst_vld_ex1 || warm_up);

  // ====================
  // EX2
  // ====================

  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (rst)
    begin
      opnd_ex2 <= '0;
    end
    else if (ld_opnd_ex2)
    begin
      opnd_ex2 <= opnd_ex1;
    end
  end

  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (rst)
    begin
      ctrl_ex2 <= '0;
    end
    else if (ld_ex2)
    begin
      ctrl_ex2 <= ctrl_ex1;
    end
  end

  // ====================
  // EX3
  // ====================

  // Holds while EX3 is stalled
  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (rst)
    begin
      ctrl_ex3 <= '0;
    end
    else if (ld_ex3)
    begin
      ctrl_ex3 <= ctrl_ex2;
    end
  end

  // ====================
  // EX4
  // ====================

  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (rst)
    begin
      ctrl_ex4 <= '0;
    end
    else if (ld_ex4)
    begin
      ctrl_ex4 <= ctrl_ex3;
    end
  end

endmodule

// File: design/fmau_ex_top.sv
/* Execute-side issue and staging path of the vector FMA unit
   No multiplier inside, outputs are the staged operands and control words */

`include "fmau_defines.svh"

module fmau_ex_top (
  input  logic                      fmau_ex2_data_clk,
  input  logic                      rst,
  input  fmau_fmt_pkg::fmau_func_u  func,
  input  logic [`FMAU_RM_W-1:0]     rm,
  input  logic [`FMAU_ID_W-1:0]     id_reg,
  input  logic [`FMAU_DATA_W-1:0]   srcv0,
  input  logic [`FMAU_DATA_W-1:0]   srcv1,
  input  logic [`FMAU_DATA_W-1:0]   srcv2,
  input  logic                      inst_vld_ex1,
  input  logic                      pipe_down_ex1,
  input  logic                      pipe_down_ex2,
  input  logic                      pipe_down_ex3,
  input  logic                      warm_up,
  output fmau_pipe_pkg::fmau_opnd_t opnd_ex2,
  output fmau_pipe_pkg::fmau_ctrl_t ctrl_ex2,
  output fmau_pipe_pkg::fmau_ctrl_t ctrl_ex3,
  output fmau_pipe_pkg::fmau_ctrl_t ctrl_ex4
);

  import fmau_pipe_pkg::*;

  fmau_op_t   op;
  fmau_ctrl_t ctrl_ex1;
  fmau_opnd_t opnd_ex1;

  // ====================
  // EX1
  // ====================

  fmau_inst_decode u_decode (
    .func     (func),
    .rm       (rm),
    .id_reg   (id_reg),
    .op       (op),
    .ctrl_ex1 (ctrl_ex1)
  );

  fmau_operand_prep u_operand_prep (
    .op       (op),
    .srcv0    (srcv0),
    .srcv1    (srcv1),
    .srcv2    (srcv2),
    .opnd_ex1 (opnd_ex1)
  );

  // ====================
  // EX2 to EX4
  // ====================

  fmau_stage_regs u_stage_regs (
    .fmau_ex2_data_clk (fmau_ex2_data_clk),
    .rst               (rst),
    .inst_vld_ex1      (inst_vld_ex1),
    .pipe_down_ex1     (pipe_down_ex1),
    .pipe_down_ex2     (pipe_down_ex2),
    .pipe_down_ex3     (pipe_down_ex3),
    .warm_up           (warm_up),
    .ctrl_ex1          (ctrl_ex1),
    .opnd_ex1          (opnd_ex1),
    .opnd_ex2          (opnd_ex2),
    .ctrl_ex2          (ctrl_ex2),
    .ctrl_ex3          (ctrl_ex3),
    .ctrl_ex4          (ctrl_ex4)
  );

endmodule

// File: sim/fmau_ex_chk.sv
/* Stage hold and reset assertions, bound into the stage registers */

module fmau_ex_chk (
  input logic                      fmau_ex2_data_clk,
  input logic                      rst,
  input logic                      inst_vld_ex1,
  input logic                      pipe_down_ex1,
  input logic                      pipe_down_ex2,
  input logic                      pipe_down_ex3,
  input logic                      warm_up,
  input fmau_pipe_pkg::fmau_opnd_t opnd_ex2,
  input fmau_pipe_pkg::fmau_ctrl_t ctrl_ex2,
  input fmau_pipe_pkg::fmau_ctrl_t ctrl_ex3,
  input fmau_pipe_pkg::fmau_ctrl_t ctrl_ex4
);

  // ====================
  // Stage hold
  // ====================

  a_ex2_hold: assert property (@(posedge fmau_ex2_data_clk) disable iff (rst)
    !(pipe_down_ex1 || warm_up) |=> $stable(ctrl_ex2))
    else $error("EX2 control changed without a load strobe");

  a_opnd_hold: assert property (@(posedge fmau_ex2_data_clk) disable iff (rst)
    !((pipe_down_ex1 || warm_up) && (inst_vld_ex1 || warm_up)) |=> $stable(opnd_ex2))
    else $error("EX2 operands changed without a valid load");

  a_ex3_hold: assert property (@(posedge fmau_ex2_data_clk) disable iff (rst)
    !(pipe_down_ex2 || warm_up) |=> $stable(ctrl_ex3))
    else $error("EX3 control changed without a load strobe");

  a_ex4_hold: assert property (@(posedge fmau_ex2_data_clk) disable iff (rst)
    !(pipe_down_ex3 || warm_up) |=> $stable(ctrl_ex4))
    else $error("EX4 control changed without a load strobe");

  // Reset clears all control
  a_rst_zero: assert property (@(posedge fmau_ex2_data_clk)
    rst |=> (ctrl_ex2 == '0) && (ctrl_ex3 == '0) && (ctrl_ex4 == '0))
    else $error("Control words not zero after reset");

endmodule

bind fmau_stage_regs fmau_ex_chk u_chk (
  .fmau_ex2_data_clk (fmau_ex2_data_clk),
  .rst               (rst),
  .inst_vld_ex1      (inst_vld_ex1),
  .pipe_down_ex1     (pipe_down_ex1),
  .pipe_down_ex2     (pipe_down_ex2),
  .pipe_down_ex3     (pipe_down_ex3),
  .warm_up           (warm_up),
  .opnd_ex2          (opnd_ex2),
  .ctrl_ex2          (ctrl_ex2),
  .ctrl_ex3          (ctrl_ex3),
  .ctrl_ex4          (ctrl_ex4)
);

// File: sim/fmau_ex_tb.sv
/* Random testbench for the FMA issue path, stops at the first mismatch
   Expected values come from a reference of the decode, operand and strobe rules */

`include "fmau_defines.svh"

module fmau_ex_tb;

  import fmau_fmt_pkg::*;
  import fmau_pipe_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DLY   = 5;
  localparam int RST_CYCLES  = 8;
  localparam int TEST_CYCLES = 600;
  localparam int TIMEOUT     = (RST_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD;

  logic                    fmau_ex2_data_clk;
  logic                    rst;
  fmau_func_u              func;
  logic [`FMAU_RM_W-1:0]   rm;
  logic [`FMAU_ID_W-1:0]   id_reg;
  logic [`FMAU_DATA_W-1:0] srcv0;
  logic [`FMAU_DATA_W-1:0] srcv1;
  logic [`FMAU_DATA_W-1:0] srcv2;
  logic                    inst_vld_ex1;
  logic                    pipe_down_ex1;
  logic                    pipe_down_ex2;
  logic                    pipe_down_ex3;
  logic                    warm_up;
  fmau_opnd_t              opnd_ex2;
  fmau_ctrl_t              ctrl_ex2;
  fmau_ctrl_t              ctrl_ex3;
  fmau_ctrl_t              ctrl_ex4;

  // Scoreboard of the three stages
  fmau_ctrl_t  exp_ctrl_ex1;
  fmau_opnd_t  exp_opnd_ex1;
  fmau_ctrl_t  m_ctrl_ex2;
  fmau_ctrl_t  m_ctrl_ex3;
  fmau_ctrl_t  m_ctrl_ex4;
  fmau_opnd_t  m_opnd_ex2;
  int          errors;

  fmau_ex_top dut0 (
    .fmau_ex2_data_clk (fmau_ex2_data_clk),
    .rst               (rst),
    .func              (func),
    .rm                (rm),
    .id_reg            (id_reg),
    .srcv0             (srcv0),
    .srcv1             (srcv1),
    .srcv2             (srcv2),
    .inst_vld_ex1      (inst_vld_ex1),
    .pipe_down_ex1     (pipe_down_ex1),
    .pipe_down_ex2     (pipe_down_ex2),
    .pipe_down_ex3     (pipe_down_ex3),
    .warm_up           (warm_up),
    .opnd_ex2          (opnd_ex2),
    .ctrl_ex2          (ctrl_ex2),
    .ctrl_ex3          (ctrl_ex3),
    .ctrl_ex4          (ctrl_ex4)
  );

  // ====================
  // Reference model
  // ====================

  // Bits 0 acc, 1 sub, 2 neg, 5 scaleb, 16 double, 17 single
  function automatic fmau_ctrl_t ref_ex1(
    input  logic [`FMAU_FUNC_W-1:0] word,
    input  logic [`FMAU_RM_W-1:0]   rm_in,
    input  logic [`FMAU_ID_W-1:0]   id_in,
    input  logic [`FMAU_DATA_W-1:0] s0,
    input  logic [`FMAU_DATA_W-1:0] s1,
    input  logic [`FMAU_DATA_W-1:0] s2,
    output fmau_opnd_t              opnd
  );
    fmau_ctrl_t            ctrl;
    logic [`FMAU_ID_W-1:0] id_eff;
    int unsigned           dsum;
    int unsigned           ssum;

    id_eff = id_in;
    if (word[5])
    begin
      id_eff[`FMAU_ID_W-1] = 1'b0;
    end
    ctrl.dbl     = word[16];
    ctrl.sgl     = word[17];
    ctrl.neg     = word[2];
    ctrl.sub     = word[1];
    ctrl.rm      = rm_in;
    ctrl.acc_upd = word[0] || (id_eff != '0);

    // Only the low bits are kept, so the exponent wraps
    dsum = s1[`FMAU_DBL_EXP_W-1:0] + `FMAU_DBL_BIAS;
    ssum = s1[`FMAU_SGL_EXP_W-1:0] + `FMAU_SGL_BIAS;
    opnd.srcv0 = s0;
    if (!word[5])
      opnd.srcv1 = s1;
    else if (word[16])
      opnd.srcv1 = {1'b0, dsum[`FMAU_DBL_EXP_W-1:0], {`FMAU_DBL_FRAC_W{1'b0}}};
    else
      opnd.srcv1 = {32'hffff_ffff, 1'b0, ssum[`FMAU_SGL_EXP_W-1:0], {`FMAU_SGL_FRAC_W{1'b0}}};
    opnd.srcv2 = word[0] ? s2 : '0;
    return ctrl;
  endfunction

  // ====================
  // Compare tasks
  // ====================

  task automatic check_ctrl(input string what, input fmau_ctrl_t got, input fmau_ctrl_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_opnd(input string what, input fmau_opnd_t got, input fmau_opnd_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // ====================
  // Stimulus
  // ====================

  task automatic drive_random();
    logic [31:0] rnd;

    rnd  = $urandom();
    func = rnd[`FMAU_FUNC_W-1:0];
    rnd  = $urandom();
    rm            = rnd[2:0];
    id_reg        = rnd[4:3];
    inst_vld_ex1  = (rnd[7:6] != 2'b00);
    pipe_down_ex1 = rnd[8];
    pipe_down_ex2 = rnd[9];
    pipe_down_ex3 = rnd[10];
    // Rare warm-up pulse
    warm_up       = (rnd[15:12] == 4'h0);
    srcv0 = {$urandom(), $urandom()};
    srcv1 = {$urandom(), $urandom()};
    srcv2 = {$urandom(), $urandom()};
  endtask

  initial
  begin
    fmau_ex2_data_clk = 1'b0;
    forever #(CLK_PERIOD / 2) fmau_ex2_data_clk = ~fmau_ex2_data_clk;
  end

  initial
  begin
    errors        = 0;
    void'($urandom(69));
    rst           = 1'b1;
    func          = '0;
    rm            = '0;
    id_reg        = '0;
    srcv0         = '0;
    srcv1         = '0;
    srcv2         = '0;
    inst_vld_ex1  = 1'b0;
    pipe_down_ex1 = 1'b0;
    pipe_down_ex2 = 1'b0;
    pipe_down_ex3 = 1'b0;
    warm_up       = 1'b0;
    repeat (RST_CYCLES) @(posedge fmau_ex2_data_clk);
    #DRIVE_DLY;
    rst = 1'b0;
    for (int i = 0; i < TEST_CYCLES; i++)
    begin
      drive_random();
      @(posedge fmau_ex2_data_clk);
      #DRIVE_DLY;
    end
    repeat (2) @(posedge fmau_ex2_data_clk);
    #DRIVE_DLY;
    if (errors == 0)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
    begin
      $display("Simulation failed");
      $fatal(1, "Mismatches were found");
    end
  end

  // ====================
  // Compare process
  // ====================

  // Inputs still hold their edge values 1 unit after the edge
  initial
  begin
    m_ctrl_ex2 = '0;
    m_ctrl_ex3 = '0;
    m_ctrl_ex4 = '0;
    m_opnd_ex2 = '0;
    forever
    begin
      @(posedge fmau_ex2_data_clk);
      #1;
      exp_ctrl_ex1 = ref_ex1(func, rm, id_reg, srcv0, srcv1, srcv2, exp_opnd_ex1);
      if (rst)
      begin
        m_ctrl_ex2 = '0;
        m_ctrl_ex3 = '0;
        m_ctrl_ex4 = '0;
        m_opnd_ex2 = '0;
      end
      else
      begin
        // Oldest stage first
        if (pipe_down_ex3 || warm_up)
          m_ctrl_ex4 = m_ctrl_ex3;
        if (pipe_down_ex2 || warm_up)
          m_ctrl_ex3 = m_ctrl_ex2;
        if (pipe_down_ex1 || warm_up)
        begin
          m_ctrl_ex2 = exp_ctrl_ex1;
          if (inst_vld_ex1 || warm_up)
            m_opnd_ex2 = exp_opnd_ex1;
        end
      end
      check_ctrl("ctrl_ex2", ctrl_ex2, m_ctrl_ex2);
      check_ctrl("ctrl_ex3", ctrl_ex3, m_ctrl_ex3);
      check_ctrl("ctrl_ex4", ctrl_ex4, m_ctrl_ex4);
      check_opnd("opnd_ex2", opnd_ex2, m_opnd_ex2);
    end
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT);
    $display("Timeout: the test did not finish within %0d time units", TIMEOUT);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: fmau_ex.f
+incdir+design
design/fmau_fmt_pkg.sv
design/fmau_pipe_pkg.sv
design/fmau_inst_decode.sv
design/fmau_operand_prep.sv
design/fmau_stage_regs.sv
design/fmau_ex_top.sv
sim/fmau_ex_chk.sv
sim/fmau_ex_tb.sv
